// File: Makefile
VERILATOR  = verilator
TOP        = channel_pair_tb
FILE_LIST  = compile.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = TEST PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
hw/chan_pkg.sv
hw/chan_fifo.sv
hw/channel_multi_cc.sv
hw/channel_steer.sv
hw/channel_merge.sv
hw/channel_pair_top.sv
tests/channel_pair_tb.sv

// File: hw/chan_fifo.sv
`default_nettype none

module chan_fifo #(
    parameter int WIDTH = 10,
    parameter int DEPTH = 16
)
(
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            wr_en,
    input  wire logic [WIDTH-1:0]                din,
    output logic                                 full,
    input  wire logic                            rd_en,
    output logic      [WIDTH-1:0]                dout,
    output logic                                 empty,
    output logic      [chan_pkg::COUNT_WIDTH-1:0] data_count
);
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(DEPTH - 1);

    logic [WIDTH-1:0]                 mem [DEPTH];
    logic [PTR_WIDTH-1:0]             wr_ptr;
    logic [PTR_WIDTH-1:0]             rd_ptr;
    logic [chan_pkg::COUNT_WIDTH-1:0] count;
    logic                             wr_fire;
    logic                             rd_fire;

    assign full       = (count == chan_pkg::COUNT_WIDTH'(DEPTH));
    assign empty      = (count == '0);
    assign data_count = count;

    assign wr_fire = wr_en && !full;   // writes into a full FIFO are dropped here
    assign rd_fire = rd_en && !empty;

    // first word fall through
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_fire)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_fire)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (rd_fire)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or one in and one out
            endcase
        end
    end

    // pointers meet only when the FIFO is empty or full
    a_ptr_match: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == rd_ptr) == (full || empty));

endmodule

`default_nettype wire

// File: hw/chan_pkg.sv
`default_nettype none

package chan_pkg;

    // item layout: payload on top, cc id in the low bits
    localparam int PC_WIDTH   = 8;
    localparam int CC_ID_BITS = 2;
    localparam int CC_COUNT   = 1 << CC_ID_BITS;
    localparam int ITEM_WIDTH = PC_WIDTH + CC_ID_BITS;

    // lane storage
    localparam int FIFO_DEPTH  = 16;
    localparam int COUNT_WIDTH = 5;     // must hold FIFO_DEPTH itself

    // wait estimate, all ones means saturated
    localparam int LATENCY_WIDTH = 10;
    localparam logic [LATENCY_WIDTH-1:0] LATENCY_MAX  = '1;
    localparam logic [LATENCY_WIDTH-1:0] LATENCY_INIT = LATENCY_WIDTH'(1);

    typedef enum logic
    {
        SEL_LANE0 = 1'b0,
        SEL_LANE1 = 1'b1
    } lane_sel_e;

endpackage

`default_nettype wire

// File: hw/channel_merge.sv
`default_nettype none

module channel_merge
(
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                lane0_out_valid,
    input  wire logic [chan_pkg::ITEM_WIDTH-1:0]     lane0_out_data,
    output logic                                     lane0_out_ready,
    output logic      [chan_pkg::LATENCY_WIDTH-1:0]  lane0_out_latency,
    input  wire logic [chan_pkg::CC_COUNT-1:0]       lane0_cc_absent,
    input  wire logic                                lane1_out_valid,
    input  wire logic [chan_pkg::ITEM_WIDTH-1:0]     lane1_out_data,
    output logic                                     lane1_out_ready,
    output logic      [chan_pkg::LATENCY_WIDTH-1:0]  lane1_out_latency,
    input  wire logic [chan_pkg::CC_COUNT-1:0]       lane1_cc_absent,
    output logic                                     out_valid,
    output logic      [chan_pkg::ITEM_WIDTH-1:0]     out_data,
    input  wire logic                                out_ready,
    input  wire logic [chan_pkg::LATENCY_WIDTH-1:0]  out_latency,
    output logic      [chan_pkg::CC_COUNT-1:0]       cc_absent
);
    chan_pkg::lane_sel_e                 turn;
    chan_pkg::lane_sel_e                 grant;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  lat_back;

    // turn only matters when both lanes hold data
    always_comb
    begin
        if (lane0_out_valid && lane1_out_valid)
            grant = turn;
        else if (lane1_out_valid)
            grant = chan_pkg::SEL_LANE1;
        else
            grant = chan_pkg::SEL_LANE0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            turn <= chan_pkg::SEL_LANE0;
        else if (out_valid && out_ready)
            turn <= (grant == chan_pkg::SEL_LANE0) ? chan_pkg::SEL_LANE1
                                                   : chan_pkg::SEL_LANE0;
    end

    assign out_valid = lane0_out_valid || lane1_out_valid;
    assign out_data  = (grant == chan_pkg::SEL_LANE0) ? lane0_out_data : lane1_out_data;

    assign lane0_out_ready = out_ready && (grant == chan_pkg::SEL_LANE0);
    assign lane1_out_ready = out_ready && (grant == chan_pkg::SEL_LANE1);

    // one extra cycle for the merge stage with saturation
    assign lat_back = (out_latency == chan_pkg::LATENCY_MAX) ? chan_pkg::LATENCY_MAX
                                                             : out_latency + 1'b1;
    assign lane0_out_latency = lat_back;
    assign lane1_out_latency = lat_back;

    // an id is absent only if neither lane holds it
    assign cc_absent = lane0_cc_absent & lane1_cc_absent;

    // a lane served while both wait must yield on the next cycle
    a_alternate: assert property (@(posedge clk) disable iff (rst)
        (lane0_out_valid && lane1_out_valid && out_ready) |=>
            (!(lane0_out_valid && lane1_out_valid) || (grant != $past(grant))));

endmodule

`default_nettype wire

// File: hw/channel_multi_cc.sv
`default_nettype none

module channel_multi_cc
(
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                in_valid,
    input  wire logic [chan_pkg::ITEM_WIDTH-1:0]     in_data,
    output logic                                     in_ready,
    output logic      [chan_pkg::LATENCY_WIDTH-1:0]  in_latency,
    output logic                                     out_valid,
    output logic      [chan_pkg::ITEM_WIDTH-1:0]     out_data,
    input  wire logic                                out_ready,
    input  wire logic [chan_pkg::LATENCY_WIDTH-1:0]  out_latency,
    output logic      [chan_pkg::CC_COUNT-1:0]       cc_absent
);
    logic                                full;
    logic                                empty;
    logic [chan_pkg::COUNT_WIDTH-1:0]    fifo_count;
    logic                                wr_fire;
    logic                                rd_fire;
    logic [chan_pkg::CC_ID_BITS-1:0]     wr_id;
    logic [chan_pkg::CC_ID_BITS-1:0]     rd_id;
    logic [chan_pkg::COUNT_WIDTH-1:0]    cc_count [chan_pkg::CC_COUNT];
    logic [chan_pkg::LATENCY_WIDTH-1:0]  old_latency;
    logic [chan_pkg::LATENCY_WIDTH:0]    lat_sum;   // one spare bit for the carry

    chan_fifo #(
        .WIDTH (chan_pkg::ITEM_WIDTH),
        .DEPTH (chan_pkg::FIFO_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_fire),
        .din        (in_data),
        .full       (full),
        .rd_en      (rd_fire),
        .dout       (out_data),
        .empty      (empty),
        .data_count (fifo_count)
    );

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign wr_fire   = in_valid && in_ready;
    assign rd_fire   = out_valid && out_ready;
    assign wr_id     = in_data[chan_pkg::CC_ID_BITS-1:0];
    assign rd_id     = out_data[chan_pkg::CC_ID_BITS-1:0];

    // downstream estimate plus one, saturating
    always_ff @(posedge clk)
    begin
        if (rst)
            old_latency <= chan_pkg::LATENCY_INIT;
        else if (out_latency == chan_pkg::LATENCY_MAX)
            old_latency <= chan_pkg::LATENCY_MAX;
        else
            old_latency <= out_latency + 1'b1;
    end

    // a new item waits behind everything already queued
    assign lat_sum    = {1'b0, old_latency} + (chan_pkg::LATENCY_WIDTH + 1)'(fifo_count);
    assign in_latency = (lat_sum > {1'b0, chan_pkg::LATENCY_MAX}) ? chan_pkg::LATENCY_MAX
                                                                  : lat_sum[chan_pkg::LATENCY_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < chan_pkg::CC_COUNT; i++)
                cc_count[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < chan_pkg::CC_COUNT; i++)
            begin
                case ({wr_fire && (wr_id == i), rd_fire && (rd_id == i)})
                    2'b10:   cc_count[i] <= cc_count[i] + 1'b1;
                    2'b01:   cc_count[i] <= cc_count[i] - 1'b1;
                    default: cc_count[i] <= cc_count[i];
                endcase
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < chan_pkg::CC_COUNT; i++)
            cc_absent[i] = (cc_count[i] == '0);
    end

    // an item leaving the FIFO must have been counted on entry
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd_fire |-> (cc_count[rd_id] != '0));

endmodule

`default_nettype wire

// File: hw/channel_pair_top.sv
`default_nettype none

module channel_pair_top
(
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                in_valid,
    input  wire logic [chan_pkg::ITEM_WIDTH-1:0]     in_data,
    output logic                                     in_ready,
    output logic      [chan_pkg::LATENCY_WIDTH-1:0]  in_latency,
    output logic                                     out_valid,
    output logic      [chan_pkg::ITEM_WIDTH-1:0]     out_data,
    input  wire logic                                out_ready,
    input  wire logic [chan_pkg::LATENCY_WIDTH-1:0]  out_latency,
    output logic      [chan_pkg::CC_COUNT-1:0]       cc_absent
);
    // steer side of each lane
    logic                                lane0_in_valid;
    logic [chan_pkg::ITEM_WIDTH-1:0]     lane0_in_data;
    logic                                lane0_in_ready;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  lane0_in_latency;
    logic [chan_pkg::CC_COUNT-1:0]       lane0_cc_absent;
    logic                                lane1_in_valid;
    logic [chan_pkg::ITEM_WIDTH-1:0]     lane1_in_data;
    logic                                lane1_in_ready;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  lane1_in_latency;
    logic [chan_pkg::CC_COUNT-1:0]       lane1_cc_absent;

    // merge side of each lane
    logic                                lane0_out_valid;
    logic [chan_pkg::ITEM_WIDTH-1:0]     lane0_out_data;
    logic                                lane0_out_ready;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  lane0_out_latency;
    logic                                lane1_out_valid;
    logic [chan_pkg::ITEM_WIDTH-1:0]     lane1_out_data;
    logic                                lane1_out_ready;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  lane1_out_latency;

    channel_steer i_steer (
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_ready         (in_ready),
        .in_latency       (in_latency),
        .lane0_in_valid   (lane0_in_valid),
        .lane0_in_data    (lane0_in_data),
        .lane0_in_ready   (lane0_in_ready),
        .lane0_in_latency (lane0_in_latency),
        .lane0_cc_absent  (lane0_cc_absent),
        .lane1_in_valid   (lane1_in_valid),
        .lane1_in_data    (lane1_in_data),
        .lane1_in_ready   (lane1_in_ready),
        .lane1_in_latency (lane1_in_latency),
        .lane1_cc_absent  (lane1_cc_absent)
    );

    channel_multi_cc i_lane0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (lane0_in_valid),
        .in_data     (lane0_in_data),
        .in_ready    (lane0_in_ready),
        .in_latency  (lane0_in_latency),
        .out_valid   (lane0_out_valid),
        .out_data    (lane0_out_data),
        .out_ready   (lane0_out_ready),
        .out_latency (lane0_out_latency),
        .cc_absent   (lane0_cc_absent)
    );

    channel_multi_cc i_lane1 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (lane1_in_valid),
        .in_data     (lane1_in_data),
        .in_ready    (lane1_in_ready),
        .in_latency  (lane1_in_latency),
        .out_valid   (lane1_out_valid),
        .out_data    (lane1_out_data),
        .out_ready   (lane1_out_ready),
        .out_latency (lane1_out_latency),
        .cc_absent   (lane1_cc_absent)
    );

    channel_merge i_merge (
        .clk               (clk),
        .rst               (rst),
        .lane0_out_valid   (lane0_out_valid),
        .lane0_out_data    (lane0_out_data),
        .lane0_out_ready   (lane0_out_ready),
        .lane0_out_latency (lane0_out_latency),
        .lane0_cc_absent   (lane0_cc_absent),
        .lane1_out_valid   (lane1_out_valid),
        .lane1_out_data    (lane1_out_data),
        .lane1_out_ready   (lane1_out_ready),
        .lane1_out_latency (lane1_out_latency),
        .lane1_cc_absent   (lane1_cc_absent),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_ready         (out_ready),
        .out_latency       (out_latency),
        .cc_absent         (cc_absent)
    );

endmodule

`default_nettype wire

// File: hw/channel_steer.sv
`default_nettype none

module channel_steer
(
    input  wire logic                                in_valid,
    input  wire logic [chan_pkg::ITEM_WIDTH-1:0]     in_data,
    output logic                                     in_ready,
    output logic      [chan_pkg::LATENCY_WIDTH-1:0]  in_latency,
    output logic                                     lane0_in_valid,
    output logic      [chan_pkg::ITEM_WIDTH-1:0]     lane0_in_data,
    input  wire logic                                lane0_in_ready,
    input  wire logic [chan_pkg::LATENCY_WIDTH-1:0]  lane0_in_latency,
    input  wire logic [chan_pkg::CC_COUNT-1:0]       lane0_cc_absent,
    output logic                                     lane1_in_valid,
    output logic      [chan_pkg::ITEM_WIDTH-1:0]     lane1_in_data,
    input  wire logic                                lane1_in_ready,
    input  wire logic [chan_pkg::LATENCY_WIDTH-1:0]  lane1_in_latency,
    input  wire logic [chan_pkg::CC_COUNT-1:0]       lane1_cc_absent
);
    logic [chan_pkg::CC_ID_BITS-1:0] cc_id;
    chan_pkg::lane_sel_e             lane_sel;

    assign cc_id = in_data[chan_pkg::CC_ID_BITS-1:0];

    always_comb
    begin
        if (!lane0_cc_absent[cc_id])
            lane_sel = chan_pkg::SEL_LANE0;   // id already lives in lane 0
        else if (!lane1_cc_absent[cc_id])
            lane_sel = chan_pkg::SEL_LANE1;
        else if (lane0_in_ready && lane1_in_ready)
            lane_sel = (lane1_in_latency < lane0_in_latency) ? chan_pkg::SEL_LANE1
                                                             : chan_pkg::SEL_LANE0;
        else if (lane1_in_ready)
            lane_sel = chan_pkg::SEL_LANE1;
        else
            lane_sel = chan_pkg::SEL_LANE0;   // none ready, lane 0 by default
    end

    assign lane0_in_valid = in_valid && (lane_sel == chan_pkg::SEL_LANE0);
    assign lane1_in_valid = in_valid && (lane_sel == chan_pkg::SEL_LANE1);
    assign lane0_in_data  = in_data;
    assign lane1_in_data  = in_data;

    assign in_ready   = (lane_sel == chan_pkg::SEL_LANE0) ? lane0_in_ready : lane1_in_ready;
    assign in_latency = (lane_sel == chan_pkg::SEL_LANE0) ? lane0_in_latency : lane1_in_latency;

    // order per cc id relies on every id living in at most one lane
    always_comb
    begin
        a_single_lane: assert final ((~lane0_cc_absent & ~lane1_cc_absent) == '0);
    end

endmodule

`default_nettype wire

// File: tests/channel_pair_tb.sv
`default_nettype none

module channel_pair_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;   // all tests need well under 1000
    localparam int RANDOM_ITEMS   = 60;
    localparam int ONOFF_ITEMS    = 80;
    localparam int QUEUED_ITEMS   = 3;

    logic                                clk;
    logic                                rst;
    logic                                in_valid;
    logic [chan_pkg::ITEM_WIDTH-1:0]     in_data;
    logic                                in_ready;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  in_latency;
    logic                                out_valid;
    logic [chan_pkg::ITEM_WIDTH-1:0]     out_data;
    logic                                out_ready;
    logic [chan_pkg::LATENCY_WIDTH-1:0]  out_latency;
    logic [chan_pkg::CC_COUNT-1:0]       cc_absent;

    // expected items, one queue per cc id
    logic [chan_pkg::ITEM_WIDTH-1:0] exp_q [chan_pkg::CC_COUNT][$];
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          items_in;
    int          items_out;
    int          cycle_count;

    channel_pair_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .in_latency  (in_latency),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .out_latency (out_latency),
        .cc_absent   (cc_absent)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the channel stopped making progress", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("MISMATCH t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // right-shifting galois form, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return bits;
    endfunction

    function automatic logic [chan_pkg::ITEM_WIDTH-1:0] random_item();
        logic [31:0] payload;
        logic [31:0] id;
        payload = take_bits(chan_pkg::PC_WIDTH);
        id      = take_bits(chan_pkg::CC_ID_BITS);
        return {payload[chan_pkg::PC_WIDTH-1:0], id[chan_pkg::CC_ID_BITS-1:0]};
    endfunction

    function automatic int pending_items();
        int total;
        total = 0;
        for (int i = 0; i < chan_pkg::CC_COUNT; i++)
            total += exp_q[i].size();
        return total;
    endfunction

    function automatic logic [chan_pkg::CC_COUNT-1:0] expected_absent();
        logic [chan_pkg::CC_COUNT-1:0] flags;
        for (int i = 0; i < chan_pkg::CC_COUNT; i++)
            flags[i] = (exp_q[i].size() == 0);
        return flags;
    endfunction

    task automatic compare_output(input logic [chan_pkg::ITEM_WIDTH-1:0] item);
        logic [chan_pkg::CC_ID_BITS-1:0] id;
        logic [chan_pkg::ITEM_WIDTH-1:0] expected;
        id = item[chan_pkg::CC_ID_BITS-1:0];
        items_out++;
        if (exp_q[id].size() == 0)
        begin
            $display("t=%0t: item %0h came out for cc id %0d with nothing pending", $time,
                     item, id);
            error_count++;
        end
        else
        begin
            expected = exp_q[id].pop_front();   // oldest item of this id
            check_equal("out_data", 32'(item), 32'(expected));
        end
    endtask

    // scoreboard, sampled at the transfer edge
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (out_valid && out_ready)
                compare_output(out_data);
            if (in_valid && in_ready)
            begin
                exp_q[in_data[chan_pkg::CC_ID_BITS-1:0]].push_back(in_data);
                items_in++;
            end
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // called just after a falling edge, returns just after one
    task automatic push_item(input logic [chan_pkg::ITEM_WIDTH-1:0] item);
        logic accepted;
        in_valid = 1'b1;
        in_data  = item;
        accepted = 1'b0;
        while (!accepted)
        begin
            @(posedge clk);
            accepted = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    // flags must track the scoreboard at every cycle while draining
    task automatic wait_drain();
        while (pending_items() != 0)
        begin
            @(negedge clk);
            check_equal("cc_absent", 32'(cc_absent), 32'(expected_absent()));
        end
        check_equal("out_valid", 32'(out_valid), 32'd0);
        check_equal("cc_absent", 32'(cc_absent), 32'({chan_pkg::CC_COUNT{1'b1}}));
    endtask

    task automatic end_test(input string name);
        $display("%s finished, errors so far %0d", name, error_count);
    endtask

    task automatic test_reset_state();
        check_equal("out_valid", 32'(out_valid), 32'd0);
        check_equal("in_ready", 32'(in_ready), 32'd1);
        check_equal("cc_absent", 32'(cc_absent), 32'hf);
        wait_cycles(2);
        check_equal("in_latency", 32'(in_latency), 32'd2);   // 0 + merge + lane
        end_test("reset state");
    endtask

    task automatic test_random_stream();
        out_ready = 1'b1;
        for (int n = 0; n < RANDOM_ITEMS; n++)
            push_item(random_item());
        wait_drain();
        end_test("random stream");
    endtask

    task automatic test_presence_flags();
        out_ready = 1'b0;
        push_item({8'h11, 2'd1});
        push_item({8'h12, 2'd1});
        push_item({8'h31, 2'd3});
        push_item({8'h32, 2'd3});
        check_equal("cc_absent", 32'(cc_absent), 32'b0101);
        out_ready = 1'b1;
        wait_drain();
        end_test("presence flags");
    endtask

    task automatic test_back_pressure();
        int out_before;
        out_ready = 1'b0;
        out_before = items_out;
        for (int n = 0; n < chan_pkg::FIFO_DEPTH; n++)
            push_item({8'(n + 8'ha0), 2'd2});
        in_valid = 1'b1;   // one more of the same id must wait
        in_data  = {8'hff, 2'd2};
        repeat (4)
        begin
            @(posedge clk);
            check_equal("in_ready", 32'(in_ready), 32'd0);
            @(negedge clk);
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        wait_drain();
        check_equal("items drained", 32'(items_out - out_before), 32'(chan_pkg::FIFO_DEPTH));
        end_test("back-pressure");
    endtask

    task automatic test_latency_estimate();
        out_ready   = 1'b0;
        out_latency = 10'd5;
        wait_cycles(2);
        check_equal("in_latency", 32'(in_latency), 32'd7);
        out_latency = '1;
        wait_cycles(2);
        check_equal("in_latency", 32'(in_latency), 32'd1023);   // saturated
        out_latency = 10'd5;
        wait_cycles(2);
        for (int n = 0; n < QUEUED_ITEMS; n++)
            push_item({8'(n + 8'h50), 2'd0});
        // in_data still holds a cc id 0 item, so its lane is selected
        check_equal("in_latency", 32'(in_latency), 32'(7 + QUEUED_ITEMS));
        out_ready   = 1'b1;
        out_latency = '0;
        wait_drain();
        end_test("latency estimate");
    endtask

    task automatic test_onoff_stream();
        int  sent;
        logic accepted;
        sent     = 0;
        in_valid = 1'b1;
        in_data  = random_item();
        while (sent < ONOFF_ITEMS)
        begin
            out_ready = (take_bits(2) != 32'd0);   // ready three cycles in four
            @(posedge clk);
            accepted = in_ready;
            @(negedge clk);
            if (accepted)
            begin
                sent++;
                in_data = random_item();
            end
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        wait_drain();
        end_test("on/off stream");
    endtask

    initial
    begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        out_latency = '0;
        lfsr_state  = 32'hd15b8479;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_random_stream();
        test_presence_flags();
        test_back_pressure();
        test_latency_estimate();
        test_onoff_stream();

        check_equal("items out", 32'(items_out), 32'(items_in));
        $display("%0d checks, %0d errors, %0d items in, %0d items out",
                 check_count, error_count, items_in, items_out);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
